/* opl_operator_engine.f */
logic/opl_pkg.sv
logic/slot_sequencer.sv
logic/operator_regs.sv
logic/phase_stage.sv
logic/wave_stage.sv
logic/opl_operator_engine.sv
verification/tb_clock.sv
verification/opl_operator_engine_props.sv
verification/opl_operator_engine_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module opl_operator_engine_tb \
		-f opl_operator_engine.f
	@out=$$(./obj_dir/Vopl_operator_engine_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir

/* verification/opl_operator_engine_tb.sv */
/*
 * directed testbench for the FM operator engine
 * a register and phase model predicts every slot result of every pass
 */
`timescale 1ns/10ps

module opl_operator_engine_tb
    import opl_pkg::*;
();

    localparam int CYCLE_LIMIT = 4000;           // tests take about 1000 cycles
    localparam int PASS_WAIT = 40;               // done is due 23 cycles after start

    logic clk;
    logic reset;
    logic wr_valid;
    logic [REG_ADDR_WIDTH-1:0] wr_address;
    logic [REG_DATA_WIDTH-1:0] wr_data;
    logic sample_en;
    logic out_valid;
    logic [SLOT_WIDTH-1:0] out_slot;
    logic signed [OP_OUT_WIDTH-1:0] out_sample;
    logic ops_done;

    int checks = 0;
    int errors = 0;
    int cycle_count = 0;
    logic [31:0] lfsr = 32'h420e;

    // model: operator fields by register offset, channel fields, per-slot state
    int m_mult [OP_REG_DEPTH];
    int m_tl [OP_REG_DEPTH];
    int m_ws [OP_REG_DEPTH];
    int m_fnum [NUM_CHANNELS];
    int m_block [NUM_CHANNELS];
    int m_kon [NUM_CHANNELS];
    int m_cnt [NUM_CHANNELS];
    int m_phase [NUM_SLOTS];
    int m_sample [NUM_SLOTS];

    tb_clock clock0 (.clk);

    opl_operator_engine dut0 (
        .clk, .reset, .wr_valid, .wr_address, .wr_data, .sample_en,
        .out_valid, .out_slot, .out_sample, .ops_done
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("Error: run stopped at the limit of %0d cycles", CYCLE_LIMIT);
            $display("%0d checks, %0d errors", checks, errors + 1);
            $display("Testbench failed");
            $finish;
        end
    end

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic int random_bits(input int n);
        int value;
        logic fb;
        value = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            value = (value << 1) | int'(fb);
        end
        return value;
    endfunction

    function automatic bit op_offset_valid(input int off);
        return off >= 0 && off < OP_REG_DEPTH && (off % 8) < 6;
    endfunction

    function automatic void model_write(input int addr, input int data);
        int off;
        off = addr - int'(MULT_BASE);
        if (op_offset_valid(off))
            m_mult[off] = data & 'hf;
        off = addr - int'(TL_BASE);
        if (op_offset_valid(off))
            m_tl[off] = data & 'h3f;
        off = addr - int'(WS_BASE);
        if (op_offset_valid(off))
            m_ws[off] = data & 1;
        off = addr - int'(FNUM_LOW_BASE);
        if (off >= 0 && off < NUM_CHANNELS)
            m_fnum[off] = (m_fnum[off] & 'h300) | data;
        off = addr - int'(KON_BLOCK_BASE);
        if (off >= 0 && off < NUM_CHANNELS) begin
            m_kon[off] = (data >> 5) & 1;
            m_block[off] = (data >> 2) & 7;
            m_fnum[off] = (m_fnum[off] & 'hff) | ((data & 3) << 8);
        end
        off = addr - int'(CNT_BASE);
        if (off >= 0 && off < NUM_CHANNELS)
            m_cnt[off] = data & 1;
    endfunction

    // one pass in slot order, carriers see this pass's modulator sample
    function automatic void model_pass();
        int pos;
        int op;
        int ch;
        int idx;
        int w;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            pos = s % 6;
            op = s + 2 * (s / 6);                // two gap offsets per group
            ch = pos % 3 + 3 * (s / 6);
            if (m_kon[ch] != 0)
                m_phase[s] = (m_phase[s] + ((m_fnum[ch] << m_block[ch]) * m_mult[op])) & 'hfffff;
            else
                m_phase[s] = 0;
            idx = m_phase[s] >> 7;
            if (pos >= 3 && m_cnt[ch] == 0)
                idx = (idx + m_sample[s - 3]) & 'h1fff;
            if (m_ws[op] != 0)
                w = (idx & 'h1000) != 0 ? -4096 : 4095;
            else
                w = (idx & 'h1000) != 0 ? idx - 8192 : idx;
            m_sample[s] = w >>> (m_tl[op] >> 3);
        end
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic write_reg(input int addr, input int data);
        @(negedge clk);
        wr_valid = 1'b1;                         // left high for back to back writes
        wr_address = 8'(addr);
        wr_data = 8'(data);
        model_write(addr, data);
    endtask

    // start a pass, optionally pulse sample_en again mid pass, check every result
    task automatic run_pass(input string name, input bit restart);
        int waited;
        int limit;
        int n_results;
        int n_done;
        waited = 0;
        limit = PASS_WAIT;
        n_results = 0;
        n_done = 0;
        model_pass();
        @(negedge clk);
        wr_valid = 1'b0;
        sample_en = 1'b1;
        while (waited < limit) begin
            @(negedge clk);
            waited++;
            sample_en = restart && waited == 8;
            if (out_valid) begin
                if (n_results >= NUM_SLOTS) begin
                    errors++;
                    $display("Error %s: result seen after the last slot", name);
                end else begin
                    check_value({name, " slot"}, n_results, int'(out_slot));
                    check_value({name, " latency"}, n_results + 5, waited);
                    check_value($sformatf("%s sample slot %0d", name, n_results),
                                m_sample[n_results], int'(out_sample));
                end
                n_results++;
            end
            if (ops_done) begin
                n_done++;
                check_value({name, " done cycle"}, NUM_SLOTS + 5, waited);
                if (n_done == 1)
                    limit = waited + 6;          // watch for stray pulses
            end
        end
        if (n_done == 0) begin
            errors++;
            $display("Error %s: no ops_done pulse within %0d cycles", name, PASS_WAIT);
        end
        check_value({name, " result count"}, NUM_SLOTS, n_results);
        check_value({name, " done count"}, 1, n_done);
    endtask

    task automatic test_register_map();
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            write_reg(int'(FNUM_LOW_BASE) + ch, 16 * ch + 9);
            write_reg(int'(KON_BLOCK_BASE) + ch, 'h20 | ((ch % 4) << 2));
            write_reg(int'(CNT_BASE) + ch, 1);
        end
        for (int s = 0; s < NUM_SLOTS; s++)
            write_reg(int'(MULT_BASE) + s + 2 * (s / 6), s % 15 + 1);
        for (int off = 0; off < 24; off++) begin
            if (off % 8 >= 6) begin              // gaps and the two past the end
                write_reg(int'(MULT_BASE) + off, 15);
                write_reg(int'(TL_BASE) + off, 63);
                write_reg(int'(WS_BASE) + off, 1);
            end
        end
        run_pass("register_map", 1'b0);
        run_pass("register_map", 1'b0);
    endtask

    task automatic test_phase_accum();
        for (int pass = 0; pass < 4; pass++) begin
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                write_reg(int'(FNUM_LOW_BASE) + ch, random_bits(8));
                write_reg(int'(KON_BLOCK_BASE) + ch, 'h20 | random_bits(5));
            end
            for (int s = 0; s < NUM_SLOTS; s++)
                write_reg(int'(MULT_BASE) + s + 2 * (s / 6), random_bits(4));
            run_pass("phase_accum", 1'b0);
        end
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
            write_reg(int'(KON_BLOCK_BASE) + ch, 0);
        run_pass("phase_clear", 1'b0);
    endtask

    task automatic test_wave_level();
        for (int pass = 0; pass < 4; pass++) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                write_reg(int'(TL_BASE) + s + 2 * (s / 6), (pass * NUM_SLOTS + s) % 64);
                write_reg(int'(WS_BASE) + s + 2 * (s / 6), random_bits(1));
            end
            for (int ch = 0; ch < NUM_CHANNELS; ch++)
                write_reg(int'(KON_BLOCK_BASE) + ch, 'h20 | random_bits(5));
            run_pass("wave_level", 1'b0);
        end
    endtask

    task automatic test_modulation();
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
            write_reg(int'(CNT_BASE) + ch, 0);
        for (int s = 0; s < NUM_SLOTS; s++) begin
            write_reg(int'(TL_BASE) + s + 2 * (s / 6), 0);
            write_reg(int'(WS_BASE) + s + 2 * (s / 6), s % 2);
        end
        repeat (3) run_pass("modulation_fm", 1'b0);
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
            write_reg(int'(CNT_BASE) + ch, 1);
        run_pass("modulation_off", 1'b0);
    endtask

    initial begin
        reset = 1'b1;
        wr_valid = 1'b0;
        wr_address = '0;
        wr_data = '0;
        sample_en = 1'b0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        run_pass("reset_idle", 1'b0);
        test_register_map();
        test_phase_accum();
        test_wave_level();
        test_modulation();
        run_pass("ignored_start", 1'b1);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* verification/opl_operator_engine_props.sv */
/*
 * concurrent checks on the slot sequencer and the result stream
 * bound into slot_sequencer and wave_stage, ports a scope lacks are tied low
 */
`timescale 1ns/10ps

module opl_operator_engine_props
    import opl_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic sample_en,
    input logic issue_valid,
    input logic [SLOT_WIDTH-1:0] issue_slot,
    input logic phase_valid,
    input logic out_valid,
    input logic [SLOT_WIDTH-1:0] out_slot,
    input logic ops_done
);

    logic last_result;

    assign last_result = out_valid && out_slot == SLOT_WIDTH'(NUM_SLOTS - 1);

    // result two stages behind a slot seen by the phase stage
    assert property (@(posedge clk) disable iff (reset) out_valid |-> $past(phase_valid, 2))
        else $error("result with no slot in flight");

    assert property (@(posedge clk) disable iff (reset) last_result |=> ops_done)
        else $error("slot 17 result without a done pulse");

    assert property (@(posedge clk) disable iff (reset) ops_done |-> $past(last_result))
        else $error("done pulse without a slot 17 result");

    assert property (@(posedge clk) disable iff (reset)
        !issue_valid && !sample_en |=> !issue_valid)
        else $error("pass started without a sample enable");

    // a start request mid pass must not touch the count
    assert property (@(posedge clk) disable iff (reset)
        issue_valid && issue_slot != SLOT_WIDTH'(NUM_SLOTS - 1)
            |=> issue_valid && issue_slot == $past(issue_slot) + 1'b1)
        else $error("slot count broken during a pass");

endmodule

bind slot_sequencer opl_operator_engine_props props_seq (
    .clk, .reset, .sample_en, .issue_valid, .issue_slot,
    .phase_valid(1'b0), .out_valid(1'b0), .out_slot('0), .ops_done(1'b0)
);

bind wave_stage opl_operator_engine_props props_wave (
    .clk, .reset, .sample_en(1'b0), .issue_valid(1'b0), .issue_slot('0),
    .phase_valid, .out_valid, .out_slot, .ops_done
);

/* verification/tb_clock.sv */
/*
 * free-running testbench clock, 4 ns period
 */
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                   // half period
    end

endmodule

/* logic/opl_operator_engine.sv */
/*
 * top level of the time-shared FM operator engine
 * sequencer, register fetch, phase and wave stages in a fixed 4-cycle chain
 */
`timescale 1ns/10ps

module opl_operator_engine
    import opl_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic wr_valid,
    input logic [REG_ADDR_WIDTH-1:0] wr_address,
    input logic [REG_DATA_WIDTH-1:0] wr_data,
    input logic sample_en,
    output logic out_valid,
    output logic [SLOT_WIDTH-1:0] out_slot,
    output logic signed [OP_OUT_WIDTH-1:0] out_sample,
    output logic ops_done
);

    logic issue_valid;
    logic [SLOT_WIDTH-1:0] issue_slot;
    logic fetch_valid;
    logic [SLOT_WIDTH-1:0] fetch_slot;
    logic [MULT_WIDTH-1:0] fetch_mult;
    logic [TL_WIDTH-1:0] fetch_tl;
    wave_t fetch_wave;
    logic [FNUM_WIDTH-1:0] fetch_fnum;
    logic [BLOCK_WIDTH-1:0] fetch_block;
    logic fetch_kon;
    logic fetch_cnt;
    logic phase_valid;
    logic [SLOT_WIDTH-1:0] phase_slot;
    logic [OP_OUT_WIDTH-1:0] phase_index;
    wave_t phase_wave;
    logic [TL_WIDTH-1:0] phase_tl;
    logic [SLOT_WIDTH-1:0] mod_slot;
    logic signed [OP_OUT_WIDTH-1:0] mod_sample;

    slot_sequencer seq0 (
        .clk, .reset, .sample_en, .issue_valid, .issue_slot
    );

    operator_regs regs0 (
        .clk, .reset, .wr_valid, .wr_address, .wr_data,
        .issue_valid, .issue_slot, .fetch_valid, .fetch_slot,
        .mult(fetch_mult), .tl(fetch_tl), .wave(fetch_wave), .fnum(fetch_fnum),
        .block(fetch_block), .kon(fetch_kon), .cnt(fetch_cnt)
    );

    phase_stage phase0 (
        .clk, .reset, .fetch_valid, .fetch_slot,
        .mult(fetch_mult), .fetch_tl, .fetch_wave, .fnum(fetch_fnum),
        .block(fetch_block), .kon(fetch_kon), .cnt(fetch_cnt),
        .mod_slot, .mod_sample, .phase_valid, .phase_slot, .phase_index,
        .wave(phase_wave), .tl(phase_tl)
    );

    wave_stage wave0 (
        .clk, .reset, .phase_valid, .phase_slot, .phase_index,
        .wave(phase_wave), .tl(phase_tl), .mod_slot, .mod_sample,
        .out_valid, .out_slot, .out_sample, .ops_done
    );

endmodule

/* logic/wave_stage.sv */
/*
 * waveform shaping and attenuation, then the output store and result stream
 * the store also feeds modulator samples back to the phase stage
 */
`timescale 1ns/10ps

module wave_stage
    import opl_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic phase_valid,
    input logic [SLOT_WIDTH-1:0] phase_slot,
    input logic [OP_OUT_WIDTH-1:0] phase_index,
    input wave_t wave,
    input logic [TL_WIDTH-1:0] tl,
    input logic [SLOT_WIDTH-1:0] mod_slot,
    output logic signed [OP_OUT_WIDTH-1:0] mod_sample,
    output logic out_valid,
    output logic [SLOT_WIDTH-1:0] out_slot,
    output logic signed [OP_OUT_WIDTH-1:0] out_sample,
    output logic ops_done
);

    logic signed [OP_OUT_WIDTH-1:0] sample_mem [NUM_SLOTS];
    logic signed [OP_OUT_WIDTH-1:0] wave_raw;
    logic signed [OP_OUT_WIDTH-1:0] wave_atten;
    logic shape_valid;
    logic [SLOT_WIDTH-1:0] shape_slot;
    logic signed [OP_OUT_WIDTH-1:0] shape_sample;

    always_comb begin
        if (wave == WAVE_SQUARE) begin
            if (phase_index[OP_OUT_WIDTH-1])
                wave_raw = {1'b1, {(OP_OUT_WIDTH-1){1'b0}}};   // -4096
            else
                wave_raw = {1'b0, {(OP_OUT_WIDTH-1){1'b1}}};   // +4095
        end else begin
            wave_raw = $signed(phase_index);     // sawtooth
        end
        wave_atten = wave_raw >>> tl[TL_WIDTH-1 -: 3];  // 6 dB steps only
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            shape_valid <= 1'b0;
            out_valid <= 1'b0;
            ops_done <= 1'b0;
            for (int i = 0; i < NUM_SLOTS; i++)
                sample_mem[i] <= '0;
        end else begin
            shape_valid <= phase_valid;
            out_valid <= shape_valid;
            ops_done <= out_valid && out_slot == SLOT_WIDTH'(NUM_SLOTS - 1);
            if (shape_valid)
                sample_mem[shape_slot] <= shape_sample;
        end
    end

    always_ff @(posedge clk) begin
        if (phase_valid) begin
            shape_slot <= phase_slot;
            shape_sample <= wave_atten;
        end
        if (shape_valid) begin
            out_slot <= shape_slot;
            out_sample <= shape_sample;
        end
    end

    assign mod_sample = sample_mem[mod_slot];    // combinational read

endmodule

/* logic/phase_stage.sv */
/*
 * per-slot phase accumulators and the FM modulation add
 * the modulator sample is read back from the wave stage output store
 */
`timescale 1ns/10ps

module phase_stage
    import opl_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic fetch_valid,
    input logic [SLOT_WIDTH-1:0] fetch_slot,
    input logic [MULT_WIDTH-1:0] mult,
    input logic [TL_WIDTH-1:0] fetch_tl,
    input wave_t fetch_wave,
    input logic [FNUM_WIDTH-1:0] fnum,
    input logic [BLOCK_WIDTH-1:0] block,
    input logic kon,
    input logic cnt,
    output logic [SLOT_WIDTH-1:0] mod_slot,
    input logic signed [OP_OUT_WIDTH-1:0] mod_sample,
    output logic phase_valid,
    output logic [SLOT_WIDTH-1:0] phase_slot,
    output logic [OP_OUT_WIDTH-1:0] phase_index,
    output wave_t wave,
    output logic [TL_WIDTH-1:0] tl
);

    logic [PHASE_WIDTH-1:0] phase_mem [NUM_SLOTS];
    logic [PHASE_WIDTH-1:0] phase_step;
    logic [PHASE_WIDTH-1:0] phase_next;
    logic [OP_OUT_WIDTH-1:0] phase_top;          // unmodulated index
    logic [OP_OUT_WIDTH-1:0] mod_term;
    logic phase_cnt;
    logic carrier;

    always_comb begin
        phase_step = (PHASE_WIDTH'(fnum) << block) * PHASE_WIDTH'(mult);
        phase_next = kon ? phase_mem[fetch_slot] + phase_step : '0;  // key off holds zero
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase_valid <= 1'b0;
            for (int i = 0; i < NUM_SLOTS; i++)
                phase_mem[i] <= '0;
        end else begin
            phase_valid <= fetch_valid;
            if (fetch_valid)
                phase_mem[fetch_slot] <= phase_next;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            phase_slot <= fetch_slot;
            phase_top <= phase_next[PHASE_WIDTH-1 -: OP_OUT_WIDTH];
            phase_cnt <= cnt;
            wave <= fetch_wave;
            tl <= fetch_tl;
        end
    end

    // slot s-3 was stored the cycle before this read
    always_comb begin
        carrier = slot_position(phase_slot) >= 3'(MOD_DISTANCE);
        mod_slot = carrier ? phase_slot - SLOT_WIDTH'(MOD_DISTANCE) : '0;
        mod_term = (carrier && !phase_cnt) ? $unsigned(mod_sample) : '0;
        phase_index = phase_top + mod_term;      // wraps
    end

endmodule

/* logic/operator_regs.sv */
/*
 * operator and channel register file with the host write decode
 * returns the parameters of an issued slot one cycle after issue
 */
`timescale 1ns/10ps

module operator_regs
    import opl_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic wr_valid,
    input logic [REG_ADDR_WIDTH-1:0] wr_address,
    input logic [REG_DATA_WIDTH-1:0] wr_data,
    input logic issue_valid,
    input logic [SLOT_WIDTH-1:0] issue_slot,
    output logic fetch_valid,
    output logic [SLOT_WIDTH-1:0] fetch_slot,
    output logic [MULT_WIDTH-1:0] mult,
    output logic [TL_WIDTH-1:0] tl,
    output wave_t wave,
    output logic [FNUM_WIDTH-1:0] fnum,
    output logic [BLOCK_WIDTH-1:0] block,
    output logic kon,
    output logic cnt
);

    logic [MULT_WIDTH-1:0] mult_mem [OP_REG_DEPTH];
    logic [TL_WIDTH-1:0] tl_mem [OP_REG_DEPTH];
    wave_t ws_mem [OP_REG_DEPTH];
    logic [FNUM_WIDTH-1:0] fnum_mem [NUM_CHANNELS];
    logic [BLOCK_WIDTH-1:0] block_mem [NUM_CHANNELS];
    logic kon_mem [NUM_CHANNELS];
    logic cnt_mem [NUM_CHANNELS];

    logic [REG_ADDR_WIDTH-1:0] mult_off, tl_off, ws_off;
    logic [REG_ADDR_WIDTH-1:0] fnum_low_off, kon_block_off, cnt_off;
    logic [1:0] issue_group;
    logic [2:0] issue_pos;
    logic [SLOT_WIDTH-1:0] op_addr;
    logic [CHAN_WIDTH-1:0] chan_addr;

    // offsets 6, 7, 14, 15 are holes in the operator map
    function automatic logic op_offset_ok(input logic [REG_ADDR_WIDTH-1:0] offset);
        return offset < REG_ADDR_WIDTH'(OP_REG_DEPTH) && offset[2:1] != 2'b11;
    endfunction

    function automatic logic chan_offset_ok(input logic [REG_ADDR_WIDTH-1:0] offset);
        return offset < REG_ADDR_WIDTH'(NUM_CHANNELS);
    endfunction

    always_comb begin
        mult_off = wr_address - MULT_BASE;       // wraps high below the base
        tl_off = wr_address - TL_BASE;
        ws_off = wr_address - WS_BASE;
        fnum_low_off = wr_address - FNUM_LOW_BASE;
        kon_block_off = wr_address - KON_BLOCK_BASE;
        cnt_off = wr_address - CNT_BASE;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < OP_REG_DEPTH; i++) begin
                mult_mem[i] <= '0;
                tl_mem[i] <= '0;
                ws_mem[i] <= WAVE_SAW;
            end
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                fnum_mem[i] <= '0;
                block_mem[i] <= '0;
                kon_mem[i] <= 1'b0;
                cnt_mem[i] <= 1'b0;
            end
        end else if (wr_valid) begin
            if (op_offset_ok(mult_off))
                mult_mem[mult_off[4:0]] <= wr_data[MULT_WIDTH-1:0];
            if (op_offset_ok(tl_off))
                tl_mem[tl_off[4:0]] <= wr_data[TL_WIDTH-1:0];
            if (op_offset_ok(ws_off))
                ws_mem[ws_off[4:0]] <= wave_t'(wr_data[0]);
            if (chan_offset_ok(fnum_low_off))
                fnum_mem[fnum_low_off[CHAN_WIDTH-1:0]][7:0] <= wr_data;
            if (chan_offset_ok(kon_block_off)) begin
                kon_mem[kon_block_off[CHAN_WIDTH-1:0]] <= wr_data[5];
                block_mem[kon_block_off[CHAN_WIDTH-1:0]] <= wr_data[4:2];
                fnum_mem[kon_block_off[CHAN_WIDTH-1:0]][9:8] <= wr_data[1:0];
            end
            if (chan_offset_ok(cnt_off))
                cnt_mem[cnt_off[CHAN_WIDTH-1:0]] <= wr_data[0];
        end
    end

    always_comb begin
        issue_group = slot_group(issue_slot);
        issue_pos = slot_position(issue_slot);
        op_addr = issue_slot + SLOT_WIDTH'({issue_group, 1'b0});  // skip two holes per group
        chan_addr = CHAN_WIDTH'(issue_pos >= 3'd3 ? issue_pos - 3'd3 : issue_pos)
                  + CHAN_WIDTH'(3 * issue_group);
    end

    always_ff @(posedge clk) begin
        if (reset)
            fetch_valid <= 1'b0;
        else
            fetch_valid <= issue_valid;
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            fetch_slot <= issue_slot;
            mult <= mult_mem[op_addr];
            tl <= tl_mem[op_addr];
            wave <= ws_mem[op_addr];
            fnum <= fnum_mem[chan_addr];
            block <= block_mem[chan_addr];
            kon <= kon_mem[chan_addr];
            cnt <= cnt_mem[chan_addr];
        end
    end

endmodule

/* logic/slot_sequencer.sv */
/*
 * idle/slot counter, one operator slot issued per clock after a sample enable
 * a sample enable seen while a pass is running has no effect
 */
`timescale 1ns/10ps

module slot_sequencer
    import opl_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic sample_en,
    output logic issue_valid,
    output logic [SLOT_WIDTH-1:0] issue_slot
);

    logic last_slot;

    assign last_slot = issue_slot == SLOT_WIDTH'(NUM_SLOTS - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
            issue_slot <= '0;
        end else if (!issue_valid) begin
            issue_valid <= sample_en;            // idle until a start request
            issue_slot <= '0;
        end else if (last_slot) begin
            issue_valid <= 1'b0;                 // pass complete, back to idle
            issue_slot <= '0;
        end else begin
            issue_slot <= issue_slot + 1'b1;
        end
    end

endmodule

/* logic/opl_pkg.sv */
/*
 * shared constants, register map and waveform type for the FM operator engine
 * import with a wildcard in the module header
 */
package opl_pkg;

    localparam int NUM_SLOTS = 18;
    localparam int NUM_CHANNELS = 9;
    localparam int GROUP_SIZE = 6;               // slots per operator group
    localparam int OP_REG_DEPTH = 22;            // operator offsets incl. gaps
    localparam int SLOT_WIDTH = 5;
    localparam int CHAN_WIDTH = 4;
    localparam int REG_ADDR_WIDTH = 8;
    localparam int REG_DATA_WIDTH = 8;
    localparam int MULT_WIDTH = 4;
    localparam int TL_WIDTH = 6;
    localparam int FNUM_WIDTH = 10;
    localparam int BLOCK_WIDTH = 3;
    localparam int PHASE_WIDTH = 20;
    localparam int OP_OUT_WIDTH = 13;
    localparam int MOD_DISTANCE = 3;             // modulator sits three slots back

    localparam logic [REG_ADDR_WIDTH-1:0] MULT_BASE = 8'h20;
    localparam logic [REG_ADDR_WIDTH-1:0] TL_BASE = 8'h40;
    localparam logic [REG_ADDR_WIDTH-1:0] FNUM_LOW_BASE = 8'hA0;
    localparam logic [REG_ADDR_WIDTH-1:0] KON_BLOCK_BASE = 8'hB0;
    localparam logic [REG_ADDR_WIDTH-1:0] CNT_BASE = 8'hC0;
    localparam logic [REG_ADDR_WIDTH-1:0] WS_BASE = 8'hE0;

    typedef enum logic {
        WAVE_SAW = 1'b0,
        WAVE_SQUARE = 1'b1
    } wave_t;

    // group of six a slot belongs to
    function automatic logic [1:0] slot_group(input logic [SLOT_WIDTH-1:0] slot);
        if (slot < SLOT_WIDTH'(GROUP_SIZE))
            return 2'd0;
        else if (slot < SLOT_WIDTH'(2 * GROUP_SIZE))
            return 2'd1;
        return 2'd2;
    endfunction

    // position 0..5 inside the group, 3 and up are carriers
    function automatic logic [2:0] slot_position(input logic [SLOT_WIDTH-1:0] slot);
        logic [SLOT_WIDTH-1:0] group_start;
        group_start = SLOT_WIDTH'(GROUP_SIZE) * SLOT_WIDTH'(slot_group(slot));
        return 3'(slot - group_start);
    endfunction

endpackage
